// File: rtl/board_pkg.sv
// board constants: header widths, db25 grouping, reset pulse lengths, stretcher states

package board_pkg;

  // ==================================================
  // board i/o widths
  // ==================================================
  localparam int key_count     = 2;    // push buttons, active low
  localparam int sw_count      = 4;    // slide switches
  localparam int io_width      = 68;   // hostmot2 i/o bits
  localparam int hm2_led_count = 4;    // one status led per db25
  localparam int gpio_width    = 36;   // pins per 2x20 header
  localparam int bits_per_db25 = 17;   // i/o bits per connector
  localparam int event_width   = 28;   // hps stm trace event word

  // ==================================================
  // reset request pulse lengths, in clocks
  // ==================================================
  localparam int cold_pulse_len  = 6;
  localparam int warm_pulse_len  = 2;
  localparam int debug_pulse_len = 32;

  // stretcher fsm
  typedef enum logic [1:0] {
    idle,        // waiting for request high
    stretch,     // pulse out, counting
    wait_low     // request still high, edges ignored
  } pulse_state_t;

  // ==================================================
  // timing defaults at 50 MHz
  // ==================================================
  localparam int default_debounce_cycles = 50000;     // 1 ms
  localparam int default_half_period     = 25000000;  // 0.5 s, 1 Hz blink

endpackage

// File: rtl/board_event_if.sv
// interface: debounced push buttons and the three hps reset request pulses

interface board_event_if
  import board_pkg::*;
();

  logic [key_count-1:0] buttons;      // debounced, active low
  logic                 cold_pulse;   // stretched, active high
  logic                 warm_pulse;
  logic                 debug_pulse;

  // producer side, debouncer and pulse stretchers
  modport src (
    output buttons,
    output cold_pulse,
    output warm_pulse,
    output debug_pulse
  );

  // consumer side
  modport sink (
    input buttons,
    input cold_pulse,
    input warm_pulse,
    input debug_pulse
  );

endinterface

// File: rtl/key_debounce.sv
// module key_debounce: two-flop synchronizer and mismatch counter per push button

module key_debounce
  import board_pkg::*;
#(
  parameter int debounce_cycles = default_debounce_cycles
) (
  input  logic                 fpga_clk_50,
  input  logic                 hps_fpga_reset_n,
  input  logic [key_count-1:0] key,
  board_event_if.src           ev
);

  localparam int               cnt_w    = $clog2(debounce_cycles + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

  logic [key_count-1:0] key_meta;           // first sync stage
  logic [key_count-1:0] key_sync;           // second sync stage
  logic [key_count-1:0] btn_q;              // debounced level
  logic [cnt_w-1:0]     mis_cnt [key_count];

  // ==================================================
  // synchronizer, idles released
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ==================================================
  // per-button mismatch counter
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      btn_q <= '1;                          // both buttons released
      for (int i = 0; i < key_count; i++)
      begin
        mis_cnt[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < key_count; i++)
      begin
        if (key_sync[i] == btn_q[i])
          mis_cnt[i] <= '0;                 // agrees, restart
        else if (mis_cnt[i] == cnt_last)
        begin
          btn_q[i]   <= key_sync[i];        // stable long enough
          mis_cnt[i] <= '0;
        end
        else
          mis_cnt[i] <= mis_cnt[i] + 1'b1;
      end
    end
  end

  assign ev.buttons = btn_q;

endmodule

// File: rtl/reset_req_pulse.sv
// module reset_req_pulse: synchronized rising edge detect with fixed-length pulse stretch

module reset_req_pulse
  import board_pkg::*;
#(
  parameter int pulse_len = cold_pulse_len
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,
  output logic pulse
);

  localparam int               len_w    = $clog2(pulse_len + 1);
  localparam logic [len_w-1:0] len_last = len_w'(pulse_len - 1);

  logic             req_meta;
  logic             req_sync;
  pulse_state_t     state;
  logic [len_w-1:0] len_cnt;     // clocks spent in stretch

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
    end
    else
    begin
      req_meta <= req;
      req_sync <= req_meta;
    end
  end

  // ==================================================
  // stretcher fsm
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state   <= idle;
      len_cnt <= '0;
    end
    else
    begin
      case (state)
        idle:
          if (req_sync)
          begin
            state   <= stretch;             // pulse rises here, 3 clk after req
            len_cnt <= '0;
          end
        stretch:
          if (len_cnt == len_last)
            state <= req_sync ? wait_low : idle;
          else
            len_cnt <= len_cnt + 1'b1;
        wait_low:
          if (!req_sync)
            state <= idle;                  // re-armed
        default:
          state <= idle;
      endcase
    end
  end

  assign pulse = (state == stretch);

endmodule

// File: rtl/status_monitor.sv
// module status_monitor: heartbeat blink counter and registered hps trace event word

module status_monitor
  import board_pkg::*;
#(
  parameter int half_period = default_half_period
) (
  input  logic                   fpga_clk_50,
  input  logic                   hps_fpga_reset_n,
  board_event_if.sink            ev,
  input  logic [sw_count-1:0]    sw,
  output logic                   heartbeat,
  output logic [event_width-1:0] stm_hw_events
);

  localparam int              hb_w        = $clog2(half_period + 1);
  localparam logic [hb_w-1:0] hb_last     = hb_w'(half_period - 1);
  localparam int              led_field_w = 7;      // former led pio field
  localparam int              pad_w       = event_width - sw_count - led_field_w - key_count;

  logic [hb_w-1:0] hb_cnt;
  logic            hb_q;

  // ==================================================
  // heartbeat
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_cnt <= '0;
      hb_q   <= 1'b0;
    end
    else if (hb_cnt == hb_last)
    begin
      hb_cnt <= '0;
      hb_q   <= ~hb_q;                  // toggle each half period
    end
    else
      hb_cnt <= hb_cnt + 1'b1;
  end

  assign heartbeat = hb_q;

  // event word, one clock behind sw and buttons
  // only the low bit of the led field is live now
  always_ff @(posedge fpga_clk_50)
  begin
    stm_hw_events <= {{pad_w{1'b0}}, sw, {(led_field_w - 1){1'b0}}, hb_q, ev.buttons};
  end

endmodule

// File: rtl/db25_pin_map.sv
// module db25_pin_map: hostmot2 i/o bits and status leds onto gpio_0/gpio_1 in db25 order

module db25_pin_map
  import board_pkg::*;
(
  input  logic [io_width-1:0]      hm2_iobits,
  input  logic [hm2_led_count-1:0] hm2_leds,
  output logic [gpio_width-1:0]    gpio_0,
  output logic [gpio_width-1:0]    gpio_1
);

  localparam int pins_per_db25 = gpio_width / 2;     // 18 header pins per connector
  localparam int last_bit      = bits_per_db25 - 1;  // bit 16 lands on base pin 0

  // both headers back to back, connector c starts at c*18
  logic [2*gpio_width-1:0] pins;

  // ==================================================
  // per connector, per bit placement
  // ==================================================
  for (genvar c = 0; c < hm2_led_count; c++)
  begin : g_conn
    localparam int base = c * pins_per_db25;

    for (genvar k = 0; k < bits_per_db25; k++)
    begin : g_bit
      // pairs walk down from pin 16/17, last bit on pin 0
      localparam int pin = (k == last_bit) ? 0 :
                           ((k % 2) == 0)  ? last_bit - k :
                                             last_bit + 2 - k;

      assign pins[base + pin] = hm2_iobits[c*bits_per_db25 + k];
    end

    assign pins[base + 1] = hm2_leds[c];            // status led on pin 1
  end

  // connectors 0,1 on gpio_0 and 2,3 on gpio_1
  assign gpio_0 = pins[gpio_width-1:0];
  assign gpio_1 = pins[2*gpio_width-1:gpio_width];

endmodule

// File: rtl/de0_nano_db25_top.sv
// module de0_nano_db25_top: button debounce, hps reset pulses, heartbeat, trace word, db25 map

module de0_nano_db25_top
  import board_pkg::*;
#(
  parameter int debounce_cycles = default_debounce_cycles,
  parameter int half_period     = default_half_period
) (
  input  logic                     fpga_clk_50,
  input  logic                     hps_fpga_reset_n,
  input  logic [key_count-1:0]     key,
  input  logic [sw_count-1:0]      sw,
  input  logic [2:0]               hps_reset_req,      // 0 cold, 1 warm, 2 debug
  input  logic [io_width-1:0]      hm2_iobits,
  input  logic [hm2_led_count-1:0] hm2_leds,
  output logic [7:0]               led,
  output logic [event_width-1:0]   stm_hw_events,
  output logic                     hps_cold_reset_req_n,
  output logic                     hps_warm_reset_req_n,
  output logic                     hps_debug_reset_req_n,
  output logic [gpio_width-1:0]    gpio_0,
  output logic [gpio_width-1:0]    gpio_1
);

  logic heartbeat;

  board_event_if ev ();

  // ==================================================
  // input side
  // ==================================================
  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .ev               (ev)
  );

  reset_req_pulse #(.pulse_len(cold_pulse_len)) cold_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[0]),
    .pulse            (ev.cold_pulse)
  );

  reset_req_pulse #(.pulse_len(warm_pulse_len)) warm_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[1]),
    .pulse            (ev.warm_pulse)
  );

  reset_req_pulse #(.pulse_len(debug_pulse_len)) debug_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[2]),
    .pulse            (ev.debug_pulse)
  );

  // hps takes the requests active low
  assign hps_cold_reset_req_n  = ~ev.cold_pulse;
  assign hps_warm_reset_req_n  = ~ev.warm_pulse;
  assign hps_debug_reset_req_n = ~ev.debug_pulse;

  // ==================================================
  // monitor and pin map
  // ==================================================
  status_monitor #(
    .half_period (half_period)
  ) status_monitor_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ev               (ev),
    .sw               (sw),
    .heartbeat        (heartbeat),
    .stm_hw_events    (stm_hw_events)
  );

  assign led = {7'b0, heartbeat};    // upper leds unused, no pio

  db25_pin_map db25_pin_map_i (
    .hm2_iobits (hm2_iobits),
    .hm2_leds   (hm2_leds),
    .gpio_0     (gpio_0),
    .gpio_1     (gpio_1)
  );

endmodule

// File: test/tb_checker.sv
// testbench checker with models of debounce, reset pulses, heartbeat, event word and pin map

module tb_checker
  import board_pkg::*;
#(
  parameter int debounce_cycles = default_debounce_cycles,
  parameter int half_period     = default_half_period
) (
  input  logic                     fpga_clk_50,
  input  logic                     hps_fpga_reset_n,
  input  logic [key_count-1:0]     key,
  input  logic [sw_count-1:0]      sw,
  input  logic [2:0]               hps_reset_req,
  input  logic [io_width-1:0]      hm2_iobits,
  input  logic [hm2_led_count-1:0] hm2_leds,
  input  logic [7:0]               led,
  input  logic [event_width-1:0]   stm_hw_events,
  input  logic                     hps_cold_reset_req_n,
  input  logic                     hps_warm_reset_req_n,
  input  logic                     hps_debug_reset_req_n,
  input  logic [gpio_width-1:0]    gpio_0,
  input  logic [gpio_width-1:0]    gpio_1,
  input  logic                     report,
  output int                       error_total
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int deb_lo = debounce_cycles;       // earliest visible change
  localparam int deb_hi = debounce_cycles + 4;   // latest visible change
  localparam int cat_reset     = 0;
  localparam int cat_debounce  = 1;
  localparam int cat_pulse     = 2;
  localparam int cat_heartbeat = 3;
  localparam int cat_event     = 4;
  localparam int cat_pinmap    = 5;

  int                   err_cnt [6];
  bit                   released;
  int                   cyc;                     // clocks since reset release
  logic [sw_count-1:0]  sw_prev;
  logic                 hb_prev;
  logic [key_count-1:0] key_prev;
  logic [key_count-1:0] btn_prev;
  int                   run_len [key_count];     // clocks key has held its level
  logic [2:0]           req_prev;
  bit                   armed [3];
  int                   pulse_start [3];
  int                   pulse_end [3];           // exclusive
  string                req_name [3];

  initial
  begin
    error_total = 0;
    released    = 1'b0;
    cyc         = 0;
    req_name[0] = "hps_cold_reset_req_n";
    req_name[1] = "hps_warm_reset_req_n";
    req_name[2] = "hps_debug_reset_req_n";
    for (int i = 0; i < 6; i++)
      err_cnt[i] = 0;
    for (int i = 0; i < key_count; i++)
      run_len[i] = 1000;
    for (int j = 0; j < 3; j++)
    begin
      armed[j]       = 1'b1;
      pulse_start[j] = 0;
      pulse_end[j]   = 0;
    end
  end

  task automatic fail_value(input int cat, input string sig, input logic [63:0] exp,
                            input logic [63:0] act);
    err_cnt[cat]++;
    error_total++;
    $display("FAIL %0d ns %s expected %0h actual %0h", $time, sig, exp, act);
  endtask

  task automatic fail_note(input int cat, input string msg);
    err_cnt[cat]++;
    error_total++;
    $display("ERROR %0d ns: %s", $time, msg);
  endtask

  // heartbeat level c clocks after reset release
  function automatic logic heartbeat_at(input int c);
    return ((c / half_period) % 2) == 1;
  endfunction

  // bit k even lands on pin 16-k and k odd on pin 18-k
  // bit 16 lands on pin 0 and the status led on pin 1
  function automatic logic [gpio_width-1:0] header_bits(input logic [io_width-1:0] io,
      input logic [hm2_led_count-1:0] leds, input int hdr);
    logic [gpio_width-1:0] h;
    int c;
    int pin;
    h = '0;
    for (int half = 0; half < 2; half++)
    begin
      c = 2 * hdr + half;
      for (int k = 0; k < bits_per_db25; k++)
      begin
        if (k == 16)
          pin = 0;
        else if (k % 2 == 0)
          pin = 16 - k;
        else
          pin = 18 - k;
        h[half * 18 + pin] = io[c * bits_per_db25 + k];
      end
      h[half * 18 + 1] = leds[c];
    end
    return h;
  endfunction

  // ==================================================
  // per-clock checks sampled mid cycle
  // ==================================================
  task automatic check_buttons();
    logic btn;
    for (int i = 0; i < key_count; i++)
    begin
      btn = stm_hw_events[i];
      if (key[i] != key_prev[i])
        run_len[i] = 0;                 // key moved
      else if (run_len[i] < 1000)
        run_len[i]++;
      if (btn != btn_prev[i] && (btn != key[i] || run_len[i] < deb_lo || run_len[i] > deb_hi))
        fail_note(cat_debounce,
                  $sformatf("button %0d changed to %0b while key %0b held %0d cycles",
                            i, btn, key[i], run_len[i]));
      if (run_len[i] == deb_hi + 1 && btn != key[i])
        fail_value(cat_debounce, $sformatf("stm_hw_events[%0d]", i), 64'(key[i]), 64'(btn));
    end
  endtask

  task automatic check_pulses();
    logic [2:0] req_n;
    logic       exp_n;
    int         len;
    req_n = {hps_debug_reset_req_n, hps_warm_reset_req_n, hps_cold_reset_req_n};
    for (int j = 0; j < 3; j++)
    begin
      len = (j == 0) ? cold_pulse_len : (j == 1) ? warm_pulse_len : debug_pulse_len;
      if (!armed[j] && cyc >= pulse_end[j] && !hps_reset_req[j])
        armed[j] = 1'b1;                // pulse over and request dropped
      if (hps_reset_req[j] && !req_prev[j] && armed[j])
      begin
        armed[j]       = 1'b0;
        pulse_start[j] = cyc + 3;
        pulse_end[j]   = cyc + 3 + len;
      end
      exp_n = !(cyc >= pulse_start[j] && cyc < pulse_end[j]);
      if (req_n[j] !== exp_n)
        fail_value(cat_pulse, req_name[j], 64'(exp_n), 64'(req_n[j]));
    end
  endtask

  task automatic check_word();
    logic                   exp_hb;
    logic [event_width-3:0] exp_ev;
    exp_hb = heartbeat_at(cyc);
    if (led !== {7'b0, exp_hb})
      fail_value(cat_heartbeat, "led", 64'({7'b0, exp_hb}), 64'(led));
    exp_ev = {15'b0, sw_prev, 6'b0, hb_prev};    // one clock behind
    if (stm_hw_events[event_width-1:2] !== exp_ev)
      fail_value(cat_event, "stm_hw_events[27:2]", 64'(exp_ev),
                 64'(stm_hw_events[event_width-1:2]));
    if (gpio_0 !== header_bits(hm2_iobits, hm2_leds, 0))
      fail_value(cat_pinmap, "gpio_0", 64'(header_bits(hm2_iobits, hm2_leds, 0)), 64'(gpio_0));
    if (gpio_1 !== header_bits(hm2_iobits, hm2_leds, 1))
      fail_value(cat_pinmap, "gpio_1", 64'(header_bits(hm2_iobits, hm2_leds, 1)), 64'(gpio_1));
  endtask

  always @(negedge fpga_clk_50)
  begin
    if (hps_fpga_reset_n)
    begin
      if (!released)
      begin
        released = 1'b1;
        cyc      = 0;
        btn_prev = stm_hw_events[1:0];
        if ({hps_cold_reset_req_n, hps_warm_reset_req_n, hps_debug_reset_req_n} !== 3'b111)
          fail_note(cat_reset, "a reset request output is low right after reset");
        if (stm_hw_events[1:0] !== 2'b11)
          fail_value(cat_reset, "stm_hw_events[1:0]", 64'h3, 64'(stm_hw_events[1:0]));
        if (led[0] !== 1'b0)
          fail_value(cat_reset, "led[0]", 64'h0, 64'(led[0]));
      end
      else
        cyc++;
      check_buttons();
      check_pulses();
      check_word();
    end
    sw_prev  = sw;                      // history for the next clock
    hb_prev  = heartbeat_at(cyc);       // model level, 0 until release
    key_prev = key;
    req_prev = hps_reset_req;
    btn_prev = stm_hw_events[1:0];
  end

  always @(posedge report)
  begin
    $display(
      "errors: reset %0d, debounce %0d, pulse %0d, heartbeat %0d, event %0d, pins %0d, total %0d",
      err_cnt[cat_reset], err_cnt[cat_debounce], err_cnt[cat_pulse],
      err_cnt[cat_heartbeat], err_cnt[cat_event], err_cnt[cat_pinmap], error_total);
  end

endmodule

// File: test/tb_top.sv
// testbench top with clock, reset, lfsr stimulus, dut instance, checker and watchdog

module tb_top
  import board_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int tb_debounce  = 16;   // short debounce for simulation
  localparam int tb_half      = 20;   // heartbeat half period
  localparam int reset_cycles = 5;
  localparam int deb_iters    = 12;
  localparam int pulse_iters  = 4;    // per reset kind
  localparam int tail_cycles  = 30;
  localparam int draw_w       = 80;

  // worst case length of one reset pulse test
  function automatic int pulse_iter_max(input int len);
    return 8 + len / 2 + len + 8 + len + 10;
  endfunction

  localparam int deb_cycles   = deb_iters * (15 + 4 + 40);
  localparam int pulse_cycles = pulse_iters * (pulse_iter_max(cold_pulse_len) +
                                pulse_iter_max(warm_pulse_len) +
                                pulse_iter_max(debug_pulse_len));
  localparam int run_limit    = reset_cycles + deb_cycles + pulse_cycles + tail_cycles + 200;

  logic                     fpga_clk_50;
  logic                     hps_fpga_reset_n;
  logic [key_count-1:0]     key;
  logic [sw_count-1:0]      sw;
  logic [2:0]               hps_reset_req;
  logic [io_width-1:0]      hm2_iobits;
  logic [hm2_led_count-1:0] hm2_leds;
  logic [7:0]               led;
  logic [event_width-1:0]   stm_hw_events;
  logic                     hps_cold_reset_req_n;
  logic                     hps_warm_reset_req_n;
  logic                     hps_debug_reset_req_n;
  logic [gpio_width-1:0]    gpio_0;
  logic [gpio_width-1:0]    gpio_1;

  logic [15:0]          lfsr;         // stimulus lfsr state
  logic [key_count-1:0] key_val;      // level to drive on key
  logic [2:0]           req_val;      // level to drive on hps_reset_req
  logic                 report;       // asks the checker for its counts
  int                   error_total;

  always #50 fpga_clk_50 = ~fpga_clk_50;   // 100 ns period

  de0_nano_db25_top #(
    .debounce_cycles (tb_debounce),
    .half_period     (tb_half)
  ) dut_i (.*);

  tb_checker #(
    .debounce_cycles (tb_debounce),
    .half_period     (tb_half)
  ) chk_i (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [draw_w-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);           // one step per bit
      v    = {v[draw_w-2:0], lfsr[0]};
    end
  endtask

  task automatic draw_int(input int n, output int r);
    logic [draw_w-1:0] t;
    draw_bits(n, t);
    r = int'(t[31:0]);
  endtask

  // ==================================================
  // one clock of stimulus with fresh random data buses
  // ==================================================
  task automatic next_cycle();
    logic [draw_w-1:0] v;
    @(posedge fpga_clk_50);
    draw_bits(io_width + hm2_led_count + sw_count, v);
    hm2_iobits    <= v[67:0];
    hm2_leds      <= v[71:68];
    sw            <= v[75:72];
    key           <= key_val;
    hps_reset_req <= req_val;
  endtask

  task automatic hold(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic debounce_phase();
    int mask;
    int glitch;
    int level;
    for (int it = 0; it < deb_iters; it++)
    begin
      draw_int(2, mask);
      if (mask == 0)
        mask = 1;
      draw_int(4, glitch);
      if (glitch == 0)
        glitch = 1;                     // 1..15 cycles is never long enough
      key_val = key_val ^ mask[1:0];
      hold(glitch);
      key_val = key_val ^ mask[1:0];    // back to the old level
      hold(4);
      draw_int(2, level);
      key_val = level[1:0];             // may or may not differ
      hold(40);
    end
  endtask

  task automatic pulse_phase();
    int len;
    int wait_n;
    int variant;
    int high_n;
    for (int j = 0; j < 3; j++)
    begin
      len = (j == 0) ? cold_pulse_len : (j == 1) ? warm_pulse_len : debug_pulse_len;
      for (int it = 0; it < pulse_iters; it++)
      begin
        draw_int(3, wait_n);
        hold(wait_n + 1);
        draw_int(1, variant);
        req_val[j] = 1'b1;
        if (variant == 1)
        begin
          hold(len / 2);                // second edge lands mid stretch
          req_val[j] = 1'b0;
          hold(1);
          req_val[j] = 1'b1;
          hold(len + 6);
        end
        else
        begin
          draw_int(5, high_n);
          hold(high_n % (len + 8) + 1);
        end
        req_val[j] = 1'b0;
        hold(len + 10);                 // quiet gap re-arms the stretcher
      end
    end
  endtask

  initial
  begin
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;
    key              = '1;
    sw               = '0;
    hps_reset_req    = '0;
    hm2_iobits       = '0;
    hm2_leds         = '0;
    key_val          = '1;
    req_val          = '0;
    lfsr             = 16'd8;           // seed
    report           = 1'b0;
    hold(reset_cycles);
    hps_fpga_reset_n <= 1'b1;
    debounce_phase();
    pulse_phase();
    hold(tail_cycles);
    report = 1'b1;
    #1;
    if (error_total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (run_limit) @(posedge fpga_clk_50);
    $display("timeout: stimulus still running after %0d cycles", run_limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: filelist.f
rtl/board_pkg.sv
rtl/board_event_if.sv
rtl/key_debounce.sv
rtl/reset_req_pulse.sv
rtl/status_monitor.sv
rtl/db25_pin_map.sv
rtl/de0_nano_db25_top.sv
test/tb_checker.sv
test/tb_top.sv

// File: Makefile
# verilator build and run of the db25 board glue testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run tb_top, search the log for the fail message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module tb_top \
	  -f filelist.f --Mdir $(OBJ_DIR) -o tb_top
	./$(OBJ_DIR)/tb_top | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "test failed, no result line"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
